/* game_pkg.sv */
package game_pkg;

    typedef logic [11:0] coord_t;  // Pixel or mouse coordinate.
    typedef logic [11:0] rgb_t;    // 4 bits each of red, green, blue.
    typedef logic [3:0]  hp_t;     // Character hit points.

    // 640x480 at 60 Hz, counted in pixel clocks.
    localparam coord_t HOR_PIXELS     = 12'd640;
    localparam coord_t HOR_TOTAL      = 12'd800;
    localparam coord_t HOR_SYNC_START = 12'd656;
    localparam coord_t HOR_SYNC_END   = 12'd752;

    localparam coord_t VER_PIXELS     = 12'd480;
    localparam coord_t VER_TOTAL      = 12'd525;
    localparam coord_t VER_SYNC_START = 12'd490;
    localparam coord_t VER_SYNC_END   = 12'd492;

    // Each mask bit covers a 4x4 block of screen pixels.
    localparam int SPRITE_SCALE = 4;

    localparam coord_t RECT_W   = 12'd32;
    localparam coord_t RECT_H   = 12'd32;
    localparam coord_t LEFT_X   = 12'd213;
    localparam coord_t RIGHT_X  = 12'd426;
    localparam coord_t TOP_Y    = 12'd320;
    localparam coord_t CENTER_X = 12'd304;
    localparam coord_t CENTER_Y = 12'd336;
    localparam coord_t FRAME_W  = 12'd2;     // Frame thickness in pixels.

    // Rows from here down are ground.
    localparam coord_t GROUND_Y = 12'd400;

    localparam rgb_t SKY_COLOR    = 12'h226;
    localparam rgb_t GROUND_COLOR = 12'h452;
    localparam rgb_t MELEE_COLOR  = 12'hC33;
    localparam rgb_t ARCHER_COLOR = 12'h3C3;
    localparam rgb_t FRAME_COLOR  = 12'hFFF;

    localparam hp_t MELEE_HP  = 4'd10;
    localparam hp_t ARCHER_HP = 4'd8;

endpackage

/* vga_timing.sv */
`timescale 1ns/1ps

module vga_timing
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    output coord_t hcount,
    output coord_t vcount,
    output logic   hsync,
    output logic   vsync,
    output logic   hblnk,
    output logic   vblnk
);

    coord_t h_next;
    coord_t v_next;
    logic   line_end;

    assign line_end = (hcount == HOR_TOTAL - 1'b1);

    always_comb begin
        h_next = line_end ? '0 : hcount + 1'b1;
        v_next = vcount;
        if (line_end) begin
            v_next = (vcount == VER_TOTAL - 1'b1) ? '0 : vcount + 1'b1;
        end
    end

    // Flags are decoded from the next count so they line up with the counters.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= h_next;
            vcount <= v_next;
            hsync  <= (h_next >= HOR_SYNC_START) && (h_next < HOR_SYNC_END);
            vsync  <= (v_next >= VER_SYNC_START) && (v_next < VER_SYNC_END);
            hblnk  <= (h_next >= HOR_PIXELS);
            vblnk  <= (v_next >= VER_PIXELS);
        end
    end

    a_hcount_range: assert property (
        @(posedge clk) disable iff (rst) hcount < HOR_TOTAL
    ) else $error("hcount out of range: %0d", hcount);

endmodule

/* mouse_click.sv */
`timescale 1ns/1ps

module mouse_click
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  coord_t mouse_x,
    input  coord_t mouse_y,
    input  logic   mouse_left,
    output coord_t pos_x,
    output coord_t pos_y,
    output logic   click
);

    logic left_q;
    logic left_qq;

    always_ff @(posedge clk) begin
        pos_x <= mouse_x;
        pos_y <= mouse_y;
    end

    // Two samples of the button give the rising edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_q  <= 1'b0;
            left_qq <= 1'b0;
            click   <= 1'b0;
        end else begin
            left_q  <= mouse_left;
            left_qq <= left_q;
            click   <= left_q && !left_qq;  // One pulse per press.
        end
    end

endmodule

/* draw_background.sv */
`timescale 1ns/1ps

module draw_background
    import game_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  coord_t hcount,
    input  coord_t vcount,
    input  logic   hsync,
    input  logic   vsync,
    input  logic   hblnk,
    input  logic   vblnk,
    output coord_t hcount_d,
    output coord_t vcount_d,
    output logic   hsync_d,
    output logic   vsync_d,
    output logic   hblnk_d,
    output logic   vblnk_d,
    output rgb_t   rgb_d
);

    rgb_t rgb_nxt;

    always_comb begin
        if (hblnk || vblnk) begin
            rgb_nxt = '0;
        end else if (vcount < GROUND_Y) begin
            rgb_nxt = SKY_COLOR;
        end else begin
            rgb_nxt = GROUND_COLOR;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount_d <= '0;
            vcount_d <= '0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
            hblnk_d  <= 1'b0;
            vblnk_d  <= 1'b0;
            rgb_d    <= '0;
        end else begin
            hcount_d <= hcount;
            vcount_d <= vcount;
            hsync_d  <= hsync;
            vsync_d  <= vsync;
            hblnk_d  <= hblnk;
            vblnk_d  <= vblnk;
            rgb_d    <= rgb_nxt;
        end
    end

endmodule

/* class_selector.sv */
`timescale 1ns/1ps

module class_selector
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] game_active,
    input  coord_t     pos_x,
    input  coord_t     pos_y,
    input  logic       click,
    input  coord_t     hcount,
    input  coord_t     vcount,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       hblnk,
    input  logic       vblnk,
    input  rgb_t       rgb,
    output coord_t     hcount_d,
    output coord_t     vcount_d,
    output logic       hsync_d,
    output logic       vsync_d,
    output logic       hblnk_d,
    output logic       vblnk_d,
    output rgb_t       rgb_d,
    output logic       char_class,
    output logic       wpn_type,
    output hp_t        char_hp
);

    // One 8-bit row per entry, bit 7 is the leftmost column.
    logic [7:0] melee_rom  [0:RECT_H/SPRITE_SCALE-1];
    logic [7:0] archer_rom [0:RECT_H/SPRITE_SCALE-1];

    logic       sel_class;    // 0 melee, 1 archer.
    logic       on_screen;
    logic       in_left;
    logic       in_right;
    logic       in_center;
    coord_t     rel_x;
    coord_t     rel_y;
    logic [2:0] mask_row;
    logic [2:0] mask_col;
    logic       melee_bit;
    logic       archer_bit;
    logic       center_bit;
    logic       on_frame;
    rgb_t       rgb_nxt;

    function automatic logic in_rect(input coord_t x, input coord_t y,
                                     input coord_t x0, input coord_t y0);
        return (x >= x0) && (x < x0 + RECT_W) && (y >= y0) && (y < y0 + RECT_H);
    endfunction

    initial begin
        $readmemh("melee.dat", melee_rom);
        $readmemh("archer.dat", archer_rom);
    end

    assign on_screen = (game_active == 2'd0);

    assign in_left   = in_rect(hcount, vcount, LEFT_X, TOP_Y);
    assign in_right  = in_rect(hcount, vcount, RIGHT_X, TOP_Y);
    assign in_center = in_rect(hcount, vcount, CENTER_X, CENTER_Y);

    // The three boxes never overlap, so one offset serves all of them.
    always_comb begin
        if (in_left) begin
            rel_x = hcount - LEFT_X;
            rel_y = vcount - TOP_Y;
        end else if (in_right) begin
            rel_x = hcount - RIGHT_X;
            rel_y = vcount - TOP_Y;
        end else if (in_center) begin
            rel_x = hcount - CENTER_X;
            rel_y = vcount - CENTER_Y;
        end else begin
            rel_x = '0;
            rel_y = '0;
        end
    end

    assign mask_row   = 3'(rel_y / SPRITE_SCALE);
    assign mask_col   = 3'(rel_x / SPRITE_SCALE);
    assign melee_bit  = melee_rom[mask_row][3'd7 - mask_col];
    assign archer_bit = archer_rom[mask_row][3'd7 - mask_col];
    assign center_bit = sel_class ? archer_bit : melee_bit;

    assign on_frame = (rel_x < FRAME_W) || (rel_x >= RECT_W - FRAME_W) ||
                      (rel_y < FRAME_W) || (rel_y >= RECT_H - FRAME_W);

    always_comb begin
        rgb_nxt = rgb;
        if (on_screen) begin
            if (in_left && melee_bit) begin
                rgb_nxt = MELEE_COLOR;
            end else if (in_right && archer_bit) begin
                rgb_nxt = ARCHER_COLOR;
            end else if (in_center) begin
                if (center_bit) begin
                    rgb_nxt = sel_class ? ARCHER_COLOR : MELEE_COLOR;
                end else if (on_frame) begin
                    rgb_nxt = FRAME_COLOR;    // Frame shows only where the sprite is clear.
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_class <= 1'b0;
        end else if (click && on_screen) begin
            if (in_rect(pos_x, pos_y, LEFT_X, TOP_Y)) begin
                sel_class <= 1'b0;
            end else if (in_rect(pos_x, pos_y, RIGHT_X, TOP_Y)) begin
                sel_class <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount_d <= '0;
            vcount_d <= '0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
            hblnk_d  <= 1'b0;
            vblnk_d  <= 1'b0;
            rgb_d    <= '0;
        end else begin
            hcount_d <= hcount;
            vcount_d <= vcount;
            hsync_d  <= hsync;
            vsync_d  <= vsync;
            hblnk_d  <= hblnk;
            vblnk_d  <= vblnk;
            rgb_d    <= rgb_nxt;
        end
    end

    assign char_class = sel_class;
    assign wpn_type   = sel_class;
    assign char_hp    = sel_class ? ARCHER_HP : MELEE_HP;

    a_hp_legal: assert property (
        @(posedge clk) disable iff (rst) (char_hp == MELEE_HP) || (char_hp == ARCHER_HP)
    ) else $error("illegal char_hp: %0d", char_hp);

endmodule

/* vga_output.sv */
`timescale 1ns/1ps

module vga_output
    import game_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic hsync,
    input  logic vsync,
    input  logic hblnk,
    input  logic vblnk,
    input  rgb_t rgb,
    output logic vga_hs,
    output logic vga_vs,
    output rgb_t vga_rgb
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vga_hs  <= 1'b0;
            vga_vs  <= 1'b0;
            vga_rgb <= '0;
        end else begin
            vga_hs  <= hsync;
            vga_vs  <= vsync;
            vga_rgb <= (hblnk || vblnk) ? '0 : rgb;  // Black in the porches.
        end
    end

    a_black_in_blank: assert property (
        @(posedge clk) disable iff (rst) (hblnk || vblnk) |=> (vga_rgb == '0)
    ) else $error("vga_rgb not black during blanking: %h", vga_rgb);

endmodule

/* game_top.sv */
`timescale 1ns/1ps

module game_top
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] game_active,
    input  coord_t     mouse_x,
    input  coord_t     mouse_y,
    input  logic       mouse_left,
    output logic       vga_hs,
    output logic       vga_vs,
    output rgb_t       vga_rgb,
    output logic       char_class,
    output hp_t        char_hp,
    output logic       wpn_type
);

    coord_t hcount, vcount;
    logic   hsync, vsync, hblnk, vblnk;

    coord_t bg_hcount, bg_vcount;
    logic   bg_hsync, bg_vsync, bg_hblnk, bg_vblnk;
    rgb_t   bg_rgb;

    logic   sel_hsync, sel_vsync, sel_hblnk, sel_vblnk;
    rgb_t   sel_rgb;

    coord_t pos_x, pos_y;
    logic   click;

    vga_timing u_vga_timing (
        .clk(clk), .rst(rst),
        .hcount(hcount), .vcount(vcount),
        .hsync(hsync), .vsync(vsync), .hblnk(hblnk), .vblnk(vblnk)
    );

    mouse_click u_mouse_click (
        .clk(clk), .rst(rst),
        .mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_left(mouse_left),
        .pos_x(pos_x), .pos_y(pos_y), .click(click)
    );

    draw_background u_draw_background (
        .clk(clk), .rst(rst),
        .hcount(hcount), .vcount(vcount),
        .hsync(hsync), .vsync(vsync), .hblnk(hblnk), .vblnk(vblnk),
        .hcount_d(bg_hcount), .vcount_d(bg_vcount),
        .hsync_d(bg_hsync), .vsync_d(bg_vsync), .hblnk_d(bg_hblnk), .vblnk_d(bg_vblnk),
        .rgb_d(bg_rgb)
    );

    // Counters end here since the output stage needs only sync and blanking.
    class_selector u_class_selector (
        .clk(clk), .rst(rst), .game_active(game_active),
        .pos_x(pos_x), .pos_y(pos_y), .click(click),
        .hcount(bg_hcount), .vcount(bg_vcount),
        .hsync(bg_hsync), .vsync(bg_vsync), .hblnk(bg_hblnk), .vblnk(bg_vblnk),
        .rgb(bg_rgb),
        .hcount_d(), .vcount_d(),
        .hsync_d(sel_hsync), .vsync_d(sel_vsync), .hblnk_d(sel_hblnk), .vblnk_d(sel_vblnk),
        .rgb_d(sel_rgb),
        .char_class(char_class), .wpn_type(wpn_type), .char_hp(char_hp)
    );

    vga_output u_vga_output (
        .clk(clk), .rst(rst),
        .hsync(sel_hsync), .vsync(sel_vsync), .hblnk(sel_hblnk), .vblnk(sel_vblnk),
        .rgb(sel_rgb),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_rgb(vga_rgb)
    );

endmodule

/* game_top_tb.sv */
`timescale 1ns/1ps

module game_top_tb
    import game_pkg::*;
();

    localparam int FRAME_CYCLES = int'(HOR_TOTAL) * int'(VER_TOTAL);
    localparam int WATCHDOG_NS  = (6 * FRAME_CYCLES + 50000) * 20;  // Six frames plus margin.

    logic       clk;
    logic       rst;
    logic [1:0] game_active;
    coord_t     mouse_x;
    coord_t     mouse_y;
    logic       mouse_left;
    logic       vga_hs;
    logic       vga_vs;
    rgb_t       vga_rgb;
    logic       char_class;
    hp_t        char_hp;
    logic       wpn_type;

    logic [7:0]  melee_mask  [0:7];
    logic [7:0]  archer_mask [0:7];
    integer      seed;
    logic        exp_class;
    int          t_h, t_v, b_h, b_v, s_h, s_v, out_h, out_v;
    logic        b_valid;
    logic [13:0] s_exp;      // {hsync, vsync, rgb}.
    logic [13:0] out_exp;
    logic        s_blank;
    logic        out_blank;
    logic        frame_req;
    logic        frame_done;
    logic        in_frame;
    int          test_errs, err_total, tests_run, tests_failed;
    int          blank_errs;

    game_top i_game_top (
        .clk(clk), .rst(rst), .game_active(game_active),
        .mouse_x(mouse_x), .mouse_y(mouse_y), .mouse_left(mouse_left),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_rgb(vga_rgb),
        .char_class(char_class), .char_hp(char_hp), .wpn_type(wpn_type)
    );

    always begin
        #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic inside_box(input int x, input int y, input int x0, input int y0);
        return (x >= x0) && (x < x0 + int'(RECT_W)) && (y >= y0) && (y < y0 + int'(RECT_H));
    endfunction

    function automatic logic sprite_bit(input logic archer, input int rx, input int ry);
        logic [7:0] row;
        row = archer ? archer_mask[ry / SPRITE_SCALE] : melee_mask[ry / SPRITE_SCALE];
        return row[7 - rx / SPRITE_SCALE];
    endfunction

    // Expected pins for one pixel of the selection screen.
    function automatic logic [13:0] expected_pixel(input int h, input int v, input logic cls,
                                                   input logic [1:0] ga);
        logic hs;
        logic vs;
        rgb_t rgb;
        int   cx;
        int   cy;
        hs = (h >= HOR_SYNC_START) && (h < HOR_SYNC_END);
        vs = (v >= VER_SYNC_START) && (v < VER_SYNC_END);
        cx = h - int'(CENTER_X);
        cy = v - int'(CENTER_Y);
        if (h >= HOR_PIXELS || v >= VER_PIXELS) begin
            rgb = '0;
        end else begin
            rgb = (v < GROUND_Y) ? SKY_COLOR : GROUND_COLOR;
            if (ga == 2'd0) begin
                if (inside_box(h, v, LEFT_X, TOP_Y)) begin
                    if (sprite_bit(1'b0, h - int'(LEFT_X), v - int'(TOP_Y)))
                        rgb = MELEE_COLOR;
                end else if (inside_box(h, v, RIGHT_X, TOP_Y)) begin
                    if (sprite_bit(1'b1, h - int'(RIGHT_X), v - int'(TOP_Y)))
                        rgb = ARCHER_COLOR;
                end else if (inside_box(h, v, CENTER_X, CENTER_Y)) begin
                    if (sprite_bit(cls, cx, cy))
                        rgb = cls ? ARCHER_COLOR : MELEE_COLOR;
                    else if (cx < 2 || cx >= 30 || cy < 2 || cy >= 30)
                        rgb = FRAME_COLOR;  // Frame is FRAME_W wide.
                end
            end
        end
        return {hs, vs, rgb};
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        test_errs++;
        err_total++;
        if (err_total <= 40)
            $display("** Error %s: expected %h, got %h at %0t ns", name, expected, actual, $time);
    endtask

    task automatic check_stats();
        if (char_class !== exp_class)
            report_mismatch("char_class", exp_class, char_class);
        if (char_hp !== (exp_class ? ARCHER_HP : MELEE_HP))
            report_mismatch("char_hp", exp_class ? ARCHER_HP : MELEE_HP, char_hp);
        if (wpn_type !== exp_class)
            report_mismatch("wpn_type", exp_class, wpn_type);
    endtask

    task automatic do_click(input int x, input int y);
        logic next_class;
        next_class = exp_class;
        if (game_active == 2'd0 && inside_box(x, y, LEFT_X, TOP_Y))
            next_class = 1'b0;
        else if (game_active == 2'd0 && inside_box(x, y, RIGHT_X, TOP_Y))
            next_class = 1'b1;
        @(negedge clk);
        mouse_x    = coord_t'(x);
        mouse_y    = coord_t'(y);
        mouse_left = 1'b1;
        repeat (3) @(posedge clk);  // Sample, click pulse, class update.
        @(negedge clk);
        exp_class  = next_class;
        check_stats();
        mouse_left = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic check_frame();
        frame_done = 1'b0;
        frame_req  = 1'b1;
        wait (frame_done);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s (%0d errors)", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // Reference pipeline: timing, background, selector, output.
    always @(posedge clk) begin
        if (rst) begin
            t_h     = 0;
            t_v     = 0;
            b_valid = 1'b0;
            s_exp   = '0;
            s_blank = 1'b0;
            s_h     = -1;
            s_v     = -1;
            out_exp = '0;
            out_blank = 1'b0;
            out_h   = -1;
            out_v   = -1;
        end else begin
            out_exp   = s_exp;
            out_blank = s_blank;
            out_h     = s_h;
            out_v     = s_v;
            s_exp     = b_valid ? expected_pixel(b_h, b_v, exp_class, game_active) : '0;
            s_blank   = b_valid && (b_h >= HOR_PIXELS || b_v >= VER_PIXELS);
            s_h       = b_valid ? b_h : -1;
            s_v       = b_valid ? b_v : -1;
            b_h       = t_h;
            b_v       = t_v;
            b_valid   = 1'b1;
            if (t_h == HOR_TOTAL - 1) begin
                t_h = 0;
                t_v = (t_v == VER_TOTAL - 1) ? 0 : t_v + 1;
            end else begin
                t_h = t_h + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (frame_req && !in_frame && out_h == 0 && out_v == 0) begin
                in_frame   = 1'b1;
                frame_req  = 1'b0;
            end
            if (out_blank) begin
                if (vga_rgb !== 12'h000) begin
                    blank_errs++;
                    report_mismatch("vga_rgb in blanking", 0, vga_rgb);
                end
            end else if (in_frame && vga_rgb !== out_exp[11:0]) begin
                report_mismatch("vga_rgb", out_exp[11:0], vga_rgb);
            end
            if (in_frame) begin
                if (vga_hs !== out_exp[13])
                    report_mismatch("vga_hs", out_exp[13], vga_hs);
                if (vga_vs !== out_exp[12])
                    report_mismatch("vga_vs", out_exp[12], vga_vs);
                if (out_h == HOR_TOTAL - 1 && out_v == VER_TOTAL - 1) begin
                    in_frame   = 1'b0;
                    frame_done = 1'b1;
                end
            end
        end
    end

    initial begin
        int x;
        int y;
        clk = 1'b0;
        rst = 1'b1;
        game_active = 2'd0;
        mouse_x = '0;
        mouse_y = '0;
        mouse_left = 1'b0;
        seed = 46004;
        exp_class = 1'b0;
        frame_req = 1'b0;
        frame_done = 1'b0;
        in_frame = 1'b0;
        test_errs = 0;
        err_total = 0;
        tests_run = 0;
        tests_failed = 0;
        blank_errs = 0;
        $readmemh("melee.dat", melee_mask);
        $readmemh("archer.dat", archer_mask);
        repeat (4) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        check_stats();
        check_frame();
        finish_test("reset state and selection frame");

        test_errs = blank_errs;
        finish_test("black during blanking");

        do_click(RIGHT_X + rand_below(RECT_W), TOP_Y + rand_below(RECT_H));
        check_frame();
        finish_test("select archer");

        repeat (4) begin
            do begin
                x = rand_below(HOR_PIXELS);
                y = rand_below(VER_PIXELS);
            end while (inside_box(x, y, LEFT_X, TOP_Y) || inside_box(x, y, RIGHT_X, TOP_Y));
            do_click(x, y);
        end
        do_click(LEFT_X + rand_below(RECT_W), TOP_Y + rand_below(RECT_H));
        finish_test("clicks outside boxes, then melee");

        // Each ignored click targets the class that is not selected.
        game_active = 2'd1 + 2'(rand_below(3));
        do_click(RIGHT_X + rand_below(RECT_W), TOP_Y + rand_below(RECT_H));
        game_active = 2'd0;
        do_click(RIGHT_X + rand_below(RECT_W), TOP_Y + rand_below(RECT_H));
        game_active = 2'd1 + 2'(rand_below(3));
        do_click(LEFT_X + rand_below(RECT_W), TOP_Y + rand_below(RECT_H));
        check_frame();
        finish_test("game active");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (tests_failed == 0 && err_total == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

/* melee.dat */
// Melee sprite mask: one 8-bit hex row per line, top row first, bit 7 is the leftmost column.
18
3C
18
7E
5A
18
24
66

/* archer.dat */
// Archer sprite mask: one 8-bit hex row per line, top row first, bit 7 is the leftmost column.
31
39
35
FF
33
35
69
CD

/* build.f */
game_pkg.sv
vga_timing.sv
mouse_click.sv
draw_background.sv
class_selector.sv
vga_output.sv
game_top.sv
game_top_tb.sv
